/* verilog/dsp_mac_cfg.svh */
`ifndef DSP_MAC_CFG_SVH
`define DSP_MAC_CFG_SVH

// lane multiplicand width.
`define DSP_A_W 10

// lane multiplier width.
`define DSP_B_W 9

// lane accumulator width, two of these make up the packed result.
`define DSP_ACC_W 32

// shift amount covers 0 to 31.
`define DSP_SHIFT_W 5

`endif

/* verilog/dsp_mac_pkg.sv */
`default_nettype none

package dsp_mac_pkg;

	`include "dsp_mac_cfg.svh"

	// signed lane operands.
	typedef logic signed [`DSP_A_W-1:0] dsp_a_t;
	typedef logic signed [`DSP_B_W-1:0] dsp_b_t;

	// signed lane accumulator.
	typedef logic signed [`DSP_ACC_W-1:0] dsp_acc_t;

	// right shift amount, always unsigned.
	typedef logic [`DSP_SHIFT_W-1:0] dsp_shift_t;

	// lane 1 in the upper half, lane 2 in the lower half.
	typedef logic [2*`DSP_ACC_W-1:0] dsp_p_t;

endpackage

`default_nettype wire

/* verilog/dsp_op_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dsp_op_if;

	import dsp_mac_pkg::*;

	dsp_a_t a1; // lane 1 operands.
	dsp_b_t b1;
	dsp_a_t a2; // lane 2 operands.
	dsp_b_t b2;

	logic subtract; // shared by both lanes.
	dsp_shift_t shift;
	logic round;

	// single-cycle strobe, qualifies everything above.
	logic load;

	modport src (
		output a1, b1, a2, b2,
		output subtract, shift, round,
		output load
	);

	modport dst (
		input a1, b1, a2, b2,
		input subtract, shift, round,
		input load
	);

endinterface

`default_nettype wire

/* verilog/dsp_operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module dsp_operand_stage (
	input  logic                   clk,
	input  logic                   reset,

	input  dsp_mac_pkg::dsp_a_t     a1_i,
	input  dsp_mac_pkg::dsp_b_t     b1_i,
	input  dsp_mac_pkg::dsp_a_t     a2_i,
	input  dsp_mac_pkg::dsp_b_t     b2_i,

	input  logic                   subtract_i,
	input  dsp_mac_pkg::dsp_shift_t shift_right_i,
	input  logic                   round_i,
	input  logic                   load_acc_i,

	dsp_op_if.src                  op
);

	// control register, one cycle behind the ports.
	always_ff @(posedge clk) begin
		if (reset) begin
			op.load     <= 1'b0;
			op.subtract <= 1'b0;
			op.shift    <= '0;
			op.round    <= 1'b0;
		end else begin
			op.load     <= load_acc_i;
			op.subtract <= subtract_i;
			op.shift    <= shift_right_i;
			op.round    <= round_i;
		end
	end

	// operand registers.
	// captured every cycle so they stay aligned with the registered strobe,
	// the accumulator ignores them unless load is high.
	always_ff @(posedge clk) begin
		op.a1 <= a1_i; // lane 1.
		op.b1 <= b1_i;
		op.a2 <= a2_i; // lane 2.
		op.b2 <= b2_i;
	end

endmodule

`default_nettype wire

/* verilog/dsp_round_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module dsp_round_shift (
	input  dsp_mac_pkg::dsp_acc_t   value_i,
	input  dsp_mac_pkg::dsp_shift_t shift_i,
	input  logic                   round_i,
	output dsp_mac_pkg::dsp_acc_t   value_o
);

	import dsp_mac_pkg::*;

	dsp_acc_t   shifted;
	dsp_shift_t rnd_pos;
	logic       rnd_bit;

	always_comb begin
		// sign fill, value_i is a signed type.
		shifted = value_i >>> shift_i;

		// last bit shifted out, only meaningful for a nonzero shift.
		rnd_pos = shift_i - 1'b1;

		// round half up.
		// a zero shift is a pass-through, so no round bit there.
		if (round_i && (shift_i != '0)) begin
			rnd_bit = value_i[rnd_pos];
		end else begin
			rnd_bit = 1'b0;
		end

		value_o = shifted + dsp_acc_t'(rnd_bit); // wraps at the lane width.
	end

endmodule

`default_nettype wire

/* verilog/dsp_fractured_accum.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_mac_cfg.svh"

module dsp_fractured_accum (
	input  logic                clk,
	input  logic                reset,

	dsp_op_if.dst               op,

	output dsp_mac_pkg::dsp_p_t  p_o,
	output logic                p_valid_o
);

	import dsp_mac_pkg::*;

	localparam int LANES  = 2;
	localparam int PROD_W = `DSP_A_W + `DSP_B_W; // full signed product.

	dsp_a_t   a_lane   [LANES];
	dsp_b_t   b_lane   [LANES];
	dsp_acc_t acc      [LANES];
	dsp_acc_t acc_next [LANES];

	logic load_q; // load delayed by one, drives the output register.

	// index 0 is lane 1, index 1 is lane 2.
	assign a_lane[0] = op.a1;
	assign b_lane[0] = op.b1;
	assign a_lane[1] = op.a2;
	assign b_lane[1] = op.b2;

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		logic signed [PROD_W-1:0] prod;
		dsp_acc_t                 prod_ext;
		dsp_acc_t                 sum;

		assign prod     = a_lane[i] * b_lane[i];
		assign prod_ext = dsp_acc_t'(prod); // sign extended.

		// add or subtract, wraps at 32 bits.
		assign sum = op.subtract ? (acc[i] - prod_ext) : (acc[i] + prod_ext);

		// shift and round sit in the same stage as the sum,
		// so back-to-back strobes see the fresh accumulator.
		dsp_round_shift u_round_shift (
			.value_i (sum),
			.shift_i (op.shift),
			.round_i (op.round),
			.value_o (acc_next[i])
		);
	end

	// lane accumulators.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < LANES; i++) begin
				acc[i] <= '0;
			end
		end else if (op.load) begin
			for (int i = 0; i < LANES; i++) begin
				acc[i] <= acc_next[i];
			end
		end
	end

	// packed result, one cycle after the accumulators.
	always_ff @(posedge clk) begin
		if (reset) begin
			load_q    <= 1'b0;
			p_o       <= '0;
			p_valid_o <= 1'b0;
		end else begin
			load_q    <= op.load;
			p_valid_o <= load_q;
			if (load_q) begin
				p_o <= {acc[0], acc[1]}; // lane 1 high, lane 2 low.
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/dsp_mac_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module dsp_mac_tile (
	input  logic                   clk,
	input  logic                   reset,

	// lane 1 operands.
	input  dsp_mac_pkg::dsp_a_t     a1_i,
	input  dsp_mac_pkg::dsp_b_t     b1_i,

	// lane 2 operands.
	input  dsp_mac_pkg::dsp_a_t     a2_i,
	input  dsp_mac_pkg::dsp_b_t     b2_i,

	// shared controls, valid with the strobe.
	input  logic                   subtract_i,
	input  dsp_mac_pkg::dsp_shift_t shift_right_i,
	input  logic                   round_i,
	input  logic                   load_acc_i,

	// packed accumulators, two cycles after the strobe.
	output dsp_mac_pkg::dsp_p_t     p_o,
	output logic                   p_valid_o
);

	// registered operands and controls.
	dsp_op_if op_if ();

	dsp_operand_stage u_operand_stage (
		.clk           (clk),
		.reset         (reset),
		.a1_i          (a1_i),
		.b1_i          (b1_i),
		.a2_i          (a2_i),
		.b2_i          (b2_i),
		.subtract_i    (subtract_i),
		.shift_right_i (shift_right_i),
		.round_i       (round_i),
		.load_acc_i    (load_acc_i),
		.op            (op_if.src)
	);

	dsp_fractured_accum u_fractured_accum (
		.clk       (clk),
		.reset     (reset),
		.op        (op_if.dst),
		.p_o       (p_o),
		.p_valid_o (p_valid_o)
	);

endmodule

`default_nettype wire

/* tb/dsp_mac_tile_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module dsp_mac_tile_asserts (
	input  logic                clk,
	input  logic                reset,
	input  logic                op_load,
	input  dsp_mac_pkg::dsp_p_t  p_o,
	input  logic                p_valid_o
);

	int fail_count = 0; // failed assertions so far.

	// registered load reaches the result strobe two cycles later.
	a_valid_after_load: assert property (
		@(posedge clk) disable iff (reset)
		op_load |-> ##2 p_valid_o
	) else begin
		fail_count++;
		$error("p_valid_o missing two cycles after a registered load");
	end

	// and never without one.
	a_valid_has_load: assert property (
		@(posedge clk) disable iff (reset)
		p_valid_o |-> $past(op_load, 2)
	) else begin
		fail_count++;
		$error("p_valid_o raised without a registered load two cycles earlier");
	end

	a_p_holds: assert property (
		@(posedge clk) disable iff (reset)
		!p_valid_o |-> $stable(p_o)
	) else begin
		fail_count++;
		$error("p_o changed while p_valid_o was low");
	end

	// no result strobe right out of reset.
	a_reset_quiet: assert property (
		@(posedge clk)
		reset |=> !p_valid_o
	) else begin
		fail_count++;
		$error("p_valid_o high in the cycle after reset");
	end

endmodule

bind dsp_mac_tile dsp_mac_tile_asserts u_asserts (
	.clk       (clk),
	.reset     (reset),
	.op_load   (op_if.load),
	.p_o       (p_o),
	.p_valid_o (p_valid_o)
);

`default_nettype wire

/* tb/dsp_mac_tile_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dsp_mac_tile_tb;

	import dsp_mac_pkg::*;

	localparam logic [31:0] LCG_SEED = 32'h4326_a1ba;
	localparam int RESULT_TIMEOUT = 20; // cycles.

	logic       clk;
	logic       reset;
	dsp_a_t     a1_i;
	dsp_b_t     b1_i;
	dsp_a_t     a2_i;
	dsp_b_t     b2_i;
	logic       subtract_i;
	dsp_shift_t shift_right_i;
	logic       round_i;
	logic       load_acc_i;
	dsp_p_t     p_o;
	logic       p_valid_o;

	dsp_p_t      expected_q [$];
	int          strobe_q [$]; // edges where the DUT sampled a strobe.
	int          edge_cnt = 0;
	dsp_p_t      last_p = '0;
	logic [31:0] rng_state;

	int error_count  = 0;
	int result_count = 0;
	int test_count   = 0;
	int cur_test     = 0;
	int test_res0;
	int test_err0;
	bit abort        = 1'b0;

	int          fd;
	int          n_fields;
	string       line;
	logic [31:0] rec_test;
	logic [31:0] rec_gap;
	dsp_a_t      rec_a1;
	dsp_b_t      rec_b1;
	dsp_a_t      rec_a2;
	dsp_b_t      rec_b2;
	logic        rec_sub;
	dsp_shift_t  rec_shift;
	logic        rec_round;
	dsp_p_t      rec_p;

	dsp_mac_tile dut (
		.clk           (clk),
		.reset         (reset),
		.a1_i          (a1_i),
		.b1_i          (b1_i),
		.a2_i          (a2_i),
		.b2_i          (b2_i),
		.subtract_i    (subtract_i),
		.shift_right_i (shift_right_i),
		.round_i       (round_i),
		.load_acc_i    (load_acc_i),
		.p_o           (p_o),
		.p_valid_o     (p_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic apply_reset();
		if (!reset) begin
			@(posedge clk);
			reset      <= 1'b1;
			load_acc_i <= 1'b0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
	endtask

	// idle cycle with random operands and controls that the DUT must ignore.
	task automatic drive_idle();
		@(posedge clk);
		rng_state = lcg_next(rng_state);
		a1_i <= rng_state[31:22];
		b1_i <= rng_state[21:13];
		rng_state = lcg_next(rng_state);
		a2_i          <= rng_state[31:22];
		b2_i          <= rng_state[21:13];
		subtract_i    <= rng_state[12];
		shift_right_i <= rng_state[11:7];
		round_i       <= rng_state[6];
		load_acc_i    <= 1'b0;
	endtask

	task automatic drive_record(input dsp_a_t a1, input dsp_b_t b1, input dsp_a_t a2,
			input dsp_b_t b2, input logic sub, input dsp_shift_t shift,
			input logic rnd, input dsp_p_t exp_p);
		@(posedge clk);
		a1_i          <= a1;
		b1_i          <= b1;
		a2_i          <= a2;
		b2_i          <= b2;
		subtract_i    <= sub;
		shift_right_i <= shift;
		round_i       <= rnd;
		load_acc_i    <= 1'b1;
		expected_q.push_back(exp_p);
	endtask

	task automatic wait_results(output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b1;
		while (expected_q.size() != 0 && cycles < RESULT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (expected_q.size() != 0) begin
			$display("ERROR at %0t: no result strobe before timeout", $time);
			error_count++;
			ok = 1'b0;
		end
	endtask

	task automatic finish_test();
		bit ok;
		if (cur_test != 0) begin
			drive_idle(); // drops the strobe.
			wait_results(ok);
			$display("test %0d: %0d results, %0d errors", cur_test,
				result_count - test_res0, error_count - test_err0);
			test_count++;
			cur_test = 0;
			if (!ok) begin
				abort = 1'b1;
			end
		end
	endtask

	// checks the values that settled before this edge.
	always @(posedge clk) begin : result_monitor
		dsp_p_t exp_p;
		int     strobe_edge;
		edge_cnt = edge_cnt + 1;
		if (reset) begin
			last_p = '0;
		end else begin
			if (load_acc_i) begin
				strobe_q.push_back(edge_cnt);
			end
			if (p_valid_o) begin
				if (expected_q.size() == 0) begin
					$display("ERROR at %0t: result strobe with no pending record", $time);
					error_count++;
				end else begin
					exp_p = expected_q.pop_front();
					strobe_edge = strobe_q.pop_front();
					check_value("p_o", exp_p, p_o);
					// p_valid_o was raised by the previous edge.
					check_value("p_valid_o latency", 64'd2, 64'(edge_cnt - 1 - strobe_edge));
					result_count++;
				end
				last_p = p_o;
			end else begin
				check_value("p_o hold", last_p, p_o);
			end
		end
	end

	initial begin
		reset         = 1'b1;
		a1_i          = '0;
		b1_i          = '0;
		a2_i          = '0;
		b2_i          = '0;
		subtract_i    = 1'b0;
		shift_right_i = '0;
		round_i       = 1'b0;
		load_acc_i    = 1'b0;
		rng_state     = LCG_SEED;

		fd = $fopen("tb/dsp_mac_input.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open the stimulus file tb/dsp_mac_input.txt");
			error_count++;
			abort = 1'b1;
		end
		apply_reset();

		while (!abort && $fgets(line, fd) != 0) begin
			if (line.len() <= 1 || line.substr(0, 0) == "#") begin
				continue; // blank or comment line.
			end
			n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", rec_test, rec_gap,
				rec_a1, rec_b1, rec_a2, rec_b2, rec_sub, rec_shift, rec_round, rec_p);
			if (n_fields != 10) begin
				$display("ERROR: malformed stimulus record: %s", line);
				error_count++;
				abort = 1'b1;
			end else if (rec_test == 0) begin
				finish_test();
				if (!abort) begin
					apply_reset();
				end
			end else begin
				if (rec_test != cur_test) begin
					finish_test();
					cur_test  = rec_test;
					test_res0 = result_count;
					test_err0 = error_count;
				end
				if (!abort) begin
					for (int g = 0; g < rec_gap; g++) begin
						drive_idle();
					end
					drive_record(rec_a1, rec_b1, rec_a2, rec_b2, rec_sub, rec_shift,
						rec_round, rec_p);
				end
			end
		end
		if (!abort) begin
			finish_test();
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		if (dut.u_asserts.fail_count != 0) begin
			$display("ERROR: %0d assertion failures", dut.u_asserts.fail_count);
			error_count += dut.u_asserts.fail_count;
		end

		$display("%0d tests, %0d results, %0d errors", test_count, result_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dsp_mac.f */
+incdir+verilog
verilog/dsp_mac_pkg.sv
verilog/dsp_op_if.sv
verilog/dsp_operand_stage.sv
verilog/dsp_round_shift.sv
verilog/dsp_fractured_accum.sv
verilog/dsp_mac_tile.sv
tb/dsp_mac_tile_asserts.sv
tb/dsp_mac_tile_tb.sv

/* Bender.yml */
package:
  name: dsp_mac

sources:
  # design sources.
  - include_dirs:
      - verilog
    files:
      - verilog/dsp_mac_pkg.sv
      - verilog/dsp_op_if.sv
      - verilog/dsp_operand_stage.sv
      - verilog/dsp_round_shift.sv
      - verilog/dsp_fractured_accum.sv
      - verilog/dsp_mac_tile.sv

  # testbench sources.
  - target: test
    files:
      - tb/dsp_mac_tile_asserts.sv
      - tb/dsp_mac_tile_tb.sv

/* tb/dsp_mac_input.txt */
# columns are test gap a1 b1 a2 b2 sub shift round expected_p in hex.
# operands are two's complement at 10 and 9 bits and test 0 asks for a reset.

# test 1 accumulates adds with shift 0.
1 0 064 003 3f9 014 0 00 0 0000012cffffff74
1 2 1ff 0ff 200 100 0 00 0 0001fe2d0001ff74
1 0 3ff 1ff 019 004 0 00 0 0001fe2e0001ffd8

0 0 000 000 000 000 0 00 0 0000000000000000

# test 2 subtracts across zero.
2 0 032 00a 014 005 0 00 0 000001f400000064
2 0 01e 00a 3ec 006 1 00 0 000000c8000000dc
2 1 028 00a 00f 014 1 00 0 ffffff38ffffffb0
2 0 3fd 064 001 001 1 00 0 00000064ffffffaf

0 0 000 000 000 000 0 00 0 0000000000000000

# test 3 shifts negative sums without round.
3 0 20c 0c8 12c 16a 0 00 0 fffe7960ffff5038
3 0 001 005 001 003 0 03 0 ffffcf2cffffea07
3 0 000 000 002 003 0 04 0 fffffcf2fffffea0
3 0 064 003 005 047 0 01 0 ffffff0f00000001

0 0 000 000 000 000 0 00 0 0000000000000000

# test 4 repeats test 3 with round half up.
4 0 20c 0c8 12c 16a 0 00 1 fffe7960ffff5038
4 0 001 005 001 003 0 03 1 ffffcf2dffffea07
4 0 000 000 002 003 0 04 1 fffffcf3fffffea1
4 0 064 003 005 047 0 01 1 ffffff1000000002

0 0 000 000 000 000 0 00 0 0000000000000000

# test 5 mixes back to back strobes with idle gaps.
5 0 007 009 3f8 00b 0 00 0 0000003fffffffa8
5 0 00a 00a 003 1fc 0 00 0 000000a3ffffff9c
5 0 002 002 3fb 005 1 00 0 0000009fffffffb5
5 5 001 001 001 002 0 02 1 00000028ffffffee
5 3 39c 19c 0c8 138 0 00 0 00002738ffff63ae
5 0 001 001 000 000 0 00 0 00002739ffff63ae
5 1 1ff 0ff 000 000 1 00 0 fffe2a38ffff63ae

0 0 000 000 000 000 0 00 0 0000000000000000

# test 6 checks that reset cleared both accumulators.
6 0 3db 029 3db 029 0 00 0 fffffa13fffffa13
